//--- src/mipsPkg.sv
package mipsPkg;

    // Datapath sizes
    localparam int dataWidth  = 32;
    localparam int regIdWidth = 5;
    localparam int regCount   = 32;

    // Fetch sequencing
    localparam logic [dataWidth-1:0] resetPc = 32'h004000a8;
    localparam logic [dataWidth-1:0] pcStep  = 32'd4;

    // Instruction field positions (MSB of each field)
    localparam int opMsb    = 31;
    localparam int rsMsb    = 25;
    localparam int rtMsb    = 20;
    localparam int rdMsb    = 15;
    localparam int shamtMsb = 10;
    localparam int immWidth = 16;

    // Kept primary opcodes
    typedef enum logic [5:0] {
        opRStyle = 6'h00,
        opAddi   = 6'h08,
        opAddiu  = 6'h09,
        opSlti   = 6'h0a,
        opSltiu  = 6'h0b,
        opAndi   = 6'h0c,
        opOri    = 6'h0d,
        opLui    = 6'h0f,
        opLw     = 6'h23,
        opSw     = 6'h2b
    } opcode_e;

    // Kept R-type function codes
    typedef enum logic [5:0] {
        functSll  = 6'h00,
        functSrl  = 6'h02,
        functSra  = 6'h03,
        functSllv = 6'h04,
        functSrlv = 6'h06,
        functSrav = 6'h07,
        functAdd  = 6'h20,
        functAddu = 6'h21,
        functSub  = 6'h22,
        functSubu = 6'h23,
        functAnd  = 6'h24,
        functOr   = 6'h25,
        functXor  = 6'h26,
        functNor  = 6'h27,
        functSlt  = 6'h2a
    } funct_e;

    // How EX picks its ALU operation
    typedef enum logic [1:0] {
        classAdd   = 2'b00,
        classSub   = 2'b01,
        classFunct = 2'b10,
        classImm   = 2'b11
    } aluClass_e;

    typedef enum logic [5:0] {
        aluAdd = 6'b000000,
        aluSub = 6'b000001,
        aluNor = 6'b010001,
        aluXor = 6'b010110,
        aluAnd = 6'b011000,
        aluLui = 6'b011010,
        aluOr  = 6'b011110,
        aluSll = 6'b100000,
        aluSrl = 6'b100001,
        aluSra = 6'b100011,
        aluLt  = 6'b110101
    } aluOp_e;

    // Operand source for the EX forwarding muxes
    typedef enum logic [1:0] {
        fromRegs = 2'b00,
        fromMem  = 2'b10,
        fromWb   = 2'b01
    } fwdSel_e;

endpackage

//--- src/mainDecoder.sv
`timescale 1ns/1ns

module mainDecoder (
    input  mipsPkg::opcode_e   opcode,
    output logic               regDst,
    output logic               regWrite,
    output logic               aluSrcImm,
    output logic               memRead,
    output logic               memWrite,
    output logic               memToReg,
    output mipsPkg::aluClass_e aluClass
);
    import mipsPkg::*;

    always_comb begin
        // Unknown opcodes fall through as a no-op
        regDst    = 1'b0;
        regWrite  = 1'b0;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        aluClass  = classAdd;

        case (opcode)
            opRStyle: begin
                // Result to rd, operation from funct
                regDst   = 1'b1;
                regWrite = 1'b1;
                aluClass = classFunct;
            end
            opLw: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
                aluClass  = classAdd;
            end
            opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                aluClass  = classAdd;
            end
            opLui, opAddi, opAddiu, opAndi, opOri, opSlti, opSltiu: begin
                // Immediate ops write rt
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluClass  = classImm;
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

//--- src/aluDecoder.sv
`timescale 1ns/1ns

module aluDecoder (
    input  mipsPkg::aluClass_e aluClass,
    input  mipsPkg::opcode_e   opcode,
    input  mipsPkg::funct_e    funct,
    output mipsPkg::aluOp_e    aluOp,
    output logic               signedOp,
    output logic               useShamt
);
    import mipsPkg::*;

    always_comb begin
        aluOp    = aluAdd;
        signedOp = 1'b0;
        useShamt = 1'b0;

        case (aluClass)
            classAdd: aluOp = aluAdd;
            classSub: aluOp = aluSub;
            classFunct: begin
                case (funct)
                    functAdd:  signedOp = 1'b1;
                    functAddu: aluOp = aluAdd;
                    functSub: begin
                        aluOp    = aluSub;
                        signedOp = 1'b1;
                    end
                    functSubu: aluOp = aluSub;
                    functAnd:  aluOp = aluAnd;
                    functOr:   aluOp = aluOr;
                    functXor:  aluOp = aluXor;
                    functNor:  aluOp = aluNor;
                    functSlt: begin
                        aluOp    = aluLt;
                        signedOp = 1'b1;
                    end
                    // Variable shifts take the amount from rs
                    functSllv: aluOp = aluSll;
                    functSrlv: aluOp = aluSrl;
                    functSrav: aluOp = aluSra;
                    functSll: begin
                        aluOp    = aluSll;
                        useShamt = 1'b1;
                    end
                    functSrl: begin
                        aluOp    = aluSrl;
                        useShamt = 1'b1;
                    end
                    functSra: begin
                        aluOp    = aluSra;
                        useShamt = 1'b1;
                    end
                    default: aluOp = aluAdd;
                endcase
            end
            default: begin
                case (opcode)
                    opAddi:  signedOp = 1'b1;
                    opAndi:  aluOp = aluAnd;
                    opOri:   aluOp = aluOr;
                    opSlti: begin
                        aluOp    = aluLt;
                        signedOp = 1'b1;
                    end
                    opSltiu: aluOp = aluLt;
                    opLui:   aluOp = aluLui;
                    default: aluOp = aluAdd;
                endcase
            end
        endcase
    end

endmodule

//--- src/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [mipsPkg::dataWidth-1:0] a,
    input  logic [mipsPkg::dataWidth-1:0] b,
    input  mipsPkg::aluOp_e               aluOp,
    input  logic                          signedOp,
    output logic [mipsPkg::dataWidth-1:0] result
);
    import mipsPkg::*;

    logic [regIdWidth-1:0] shiftAmount;
    logic                  lessThan;

    // Shift amount comes from the low bits of operand a
    assign shiftAmount = a[regIdWidth-1:0];

    always_comb begin
        if (signedOp) begin
            lessThan = $signed(a) < $signed(b);
        end else begin
            lessThan = a < b;
        end
    end

    always_comb begin
        case (aluOp)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluXor: result = a ^ b;
            aluNor: result = ~(a | b);
            aluSll: result = b << shiftAmount;
            aluSrl: result = b >> shiftAmount;
            aluSra: result = $signed(b) >>> shiftAmount;
            aluLt:  result = {{(dataWidth-1){1'b0}}, lessThan};
            // Immediate into the upper half
            aluLui: result = {b[immWidth-1:0], {(dataWidth-immWidth){1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic                           iClk,
    input  logic                           iRst_n,
    input  logic [mipsPkg::regIdWidth-1:0] readIdA,
    input  logic [mipsPkg::regIdWidth-1:0] readIdB,
    output logic [mipsPkg::dataWidth-1:0]  readDataA,
    output logic [mipsPkg::dataWidth-1:0]  readDataB,
    input  logic [mipsPkg::regIdWidth-1:0] writeId,
    input  logic [mipsPkg::dataWidth-1:0]  writeData,
    input  logic                           writeEn
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [regCount];
    logic                 writeLive;

    // Register 0 never takes a write
    assign writeLive = writeEn && (writeId != '0);

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeId] <= writeData;
        end
    end

    // Write-through so ID sees the value WB is writing this cycle
    assign readDataA = (writeLive && writeId == readIdA) ? writeData : regs[readIdA];
    assign readDataB = (writeLive && writeId == readIdB) ? writeData : regs[readIdB];

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  logic [mipsPkg::regIdWidth-1:0] idRs,
    input  logic [mipsPkg::regIdWidth-1:0] idRt,
    input  logic [mipsPkg::regIdWidth-1:0] exRs,
    input  logic [mipsPkg::regIdWidth-1:0] exRt,
    input  logic [mipsPkg::regIdWidth-1:0] memDest,
    input  logic [mipsPkg::regIdWidth-1:0] wbDest,
    input  logic                           exMemRead,
    input  logic                           memRegWrite,
    input  logic                           wbRegWrite,
    output mipsPkg::fwdSel_e               fwdA,
    output mipsPkg::fwdSel_e               fwdB,
    output logic                           stall
);
    import mipsPkg::*;

    // Newest producer wins, register 0 is never forwarded
    function automatic fwdSel_e pickSource(input logic [regIdWidth-1:0] src);
        fwdSel_e sel;
        sel = fromRegs;
        if (memRegWrite && memDest != '0 && memDest == src) begin
            sel = fromMem;
        end else if (wbRegWrite && wbDest != '0 && wbDest == src) begin
            sel = fromWb;
        end
        return sel;
    endfunction

    assign fwdA = pickSource(exRs);
    assign fwdB = pickSource(exRt);

    // Load in EX feeding the instruction in ID
    assign stall = exMemRead && (exRt != '0) && ((exRt == idRs) || (exRt == idRt));

endmodule

//--- src/pipelineCore.sv
`timescale 1ns/1ns

module pipelineCore (
    input  logic                          iClk,
    input  logic                          iRst_n,
    output logic [mipsPkg::dataWidth-1:0] instAddr,
    input  logic [mipsPkg::dataWidth-1:0] inst,
    output logic [mipsPkg::dataWidth-1:0] memAddr,
    output logic [mipsPkg::dataWidth-1:0] memWrData,
    output logic                          memWrite,
    output logic                          memRead,
    input  logic [mipsPkg::dataWidth-1:0] memRdData
);
    import mipsPkg::*;

    logic [dataWidth-1:0]  pc;
    logic                  stall;
    logic [dataWidth-1:0]  ifIdInst;

    // ID stage
    logic [regIdWidth-1:0] idRs;
    logic [regIdWidth-1:0] idRt;
    logic [dataWidth-1:0]  idRegA;
    logic [dataWidth-1:0]  idRegB;
    logic                  idRegDst;
    logic                  idRegWrite;
    logic                  idAluSrcImm;
    logic                  idLoad;
    logic                  idStore;
    logic                  idMemToReg;
    aluClass_e             idAluClass;

    // ID/EX register
    logic [dataWidth-1:0]  idExInst;
    logic [dataWidth-1:0]  idExRegA;
    logic [dataWidth-1:0]  idExRegB;
    logic                  idExRegDst;
    logic                  idExRegWrite;
    logic                  idExAluSrcImm;
    logic                  idExLoad;
    logic                  idExStore;
    logic                  idExMemToReg;
    aluClass_e             idExAluClass;

    // EX stage
    logic [regIdWidth-1:0] exRs;
    logic [regIdWidth-1:0] exRt;
    logic [regIdWidth-1:0] exRd;
    logic [regIdWidth-1:0] exShamt;
    logic [regIdWidth-1:0] exDest;
    logic [immWidth-1:0]   exImm;
    logic [dataWidth-1:0]  exImmExt;
    logic [dataWidth-1:0]  exSrcA;
    logic [dataWidth-1:0]  exSrcB;
    logic [dataWidth-1:0]  aluA;
    logic [dataWidth-1:0]  aluB;
    logic [dataWidth-1:0]  aluResult;
    aluOp_e                exAluOp;
    logic                  exSignedOp;
    logic                  exUseShamt;
    fwdSel_e               fwdA;
    fwdSel_e               fwdB;

    // EX/MEM register
    logic [dataWidth-1:0]  exMemAluResult;
    logic [dataWidth-1:0]  exMemStoreData;
    logic [regIdWidth-1:0] exMemDest;
    logic                  exMemRegWrite;
    logic                  exMemLoad;
    logic                  exMemStore;
    logic                  exMemMemToReg;

    // MEM/WB register
    logic [dataWidth-1:0]  memWbAluResult;
    logic [dataWidth-1:0]  memWbRdData;
    logic [regIdWidth-1:0] memWbDest;
    logic                  memWbRegWrite;
    logic                  memWbMemToReg;
    logic [dataWidth-1:0]  wbData;

    function automatic logic [dataWidth-1:0] forwardPick(
        input fwdSel_e              sel,
        input logic [dataWidth-1:0] regVal,
        input logic [dataWidth-1:0] memVal,
        input logic [dataWidth-1:0] wbVal
    );
        case (sel)
            fromMem: return memVal;
            fromWb:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // IF: PC and IF/ID hold during a load-use stall
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            pc       <= resetPc;
            ifIdInst <= '0;
        end else if (!stall) begin
            pc       <= pc + pcStep;
            ifIdInst <= inst;
        end
    end

    assign instAddr = pc;

    // ID
    assign idRs = ifIdInst[rsMsb -: regIdWidth];
    assign idRt = ifIdInst[rtMsb -: regIdWidth];

    mainDecoder mainDecoder_inst (
        .opcode    (opcode_e'(ifIdInst[opMsb -: $bits(opcode_e)])),
        .regDst    (idRegDst),
        .regWrite  (idRegWrite),
        .aluSrcImm (idAluSrcImm),
        .memRead   (idLoad),
        .memWrite  (idStore),
        .memToReg  (idMemToReg),
        .aluClass  (idAluClass)
    );

    regFile regFile_inst (
        .iClk      (iClk),
        .iRst_n    (iRst_n),
        .readIdA   (idRs),
        .readIdB   (idRt),
        .readDataA (idRegA),
        .readDataB (idRegB),
        .writeId   (memWbDest),
        .writeData (wbData),
        .writeEn   (memWbRegWrite)
    );

    // ID/EX takes a bubble while stalled
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n || stall) begin
            idExInst      <= '0;
            idExRegA      <= '0;
            idExRegB      <= '0;
            idExRegDst    <= 1'b0;
            idExRegWrite  <= 1'b0;
            idExAluSrcImm <= 1'b0;
            idExLoad      <= 1'b0;
            idExStore     <= 1'b0;
            idExMemToReg  <= 1'b0;
            idExAluClass  <= classAdd;
        end else begin
            idExInst      <= ifIdInst;
            idExRegA      <= idRegA;
            idExRegB      <= idRegB;
            idExRegDst    <= idRegDst;
            idExRegWrite  <= idRegWrite;
            idExAluSrcImm <= idAluSrcImm;
            idExLoad      <= idLoad;
            idExStore     <= idStore;
            idExMemToReg  <= idMemToReg;
            idExAluClass  <= idAluClass;
        end
    end

    // EX
    assign exRs     = idExInst[rsMsb -: regIdWidth];
    assign exRt     = idExInst[rtMsb -: regIdWidth];
    assign exRd     = idExInst[rdMsb -: regIdWidth];
    assign exShamt  = idExInst[shamtMsb -: regIdWidth];
    assign exImm    = idExInst[immWidth-1:0];
    assign exImmExt = {{(dataWidth-immWidth){exImm[immWidth-1]}}, exImm};
    assign exDest   = idExRegDst ? exRd : exRt;

    hazardUnit hazardUnit_inst (
        .idRs        (idRs),
        .idRt        (idRt),
        .exRs        (exRs),
        .exRt        (exRt),
        .memDest     (exMemDest),
        .wbDest      (memWbDest),
        .exMemRead   (idExLoad),
        .memRegWrite (exMemRegWrite),
        .wbRegWrite  (memWbRegWrite),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .stall       (stall)
    );

    assign exSrcA = forwardPick(fwdA, idExRegA, exMemAluResult, wbData);
    assign exSrcB = forwardPick(fwdB, idExRegB, exMemAluResult, wbData);
    assign aluA   = exUseShamt ? {{(dataWidth-regIdWidth){1'b0}}, exShamt} : exSrcA;
    assign aluB   = idExAluSrcImm ? exImmExt : exSrcB;

    aluDecoder aluDecoder_inst (
        .aluClass (idExAluClass),
        .opcode   (opcode_e'(idExInst[opMsb -: $bits(opcode_e)])),
        .funct    (funct_e'(idExInst[$bits(funct_e)-1:0])),
        .aluOp    (exAluOp),
        .signedOp (exSignedOp),
        .useShamt (exUseShamt)
    );

    alu alu_inst (
        .a        (aluA),
        .b        (aluB),
        .aluOp    (exAluOp),
        .signedOp (exSignedOp),
        .result   (aluResult)
    );

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            exMemAluResult <= '0;
            exMemStoreData <= '0;
            exMemDest      <= '0;
            exMemRegWrite  <= 1'b0;
            exMemLoad      <= 1'b0;
            exMemStore     <= 1'b0;
            exMemMemToReg  <= 1'b0;
        end else begin
            exMemAluResult <= aluResult;
            exMemStoreData <= exSrcB;
            exMemDest      <= exDest;
            exMemRegWrite  <= idExRegWrite;
            exMemLoad      <= idExLoad;
            exMemStore     <= idExStore;
            exMemMemToReg  <= idExMemToReg;
        end
    end

    // MEM
    assign memAddr   = exMemAluResult;
    assign memWrData = exMemStoreData;
    assign memWrite  = exMemStore;
    assign memRead   = exMemLoad;

    // Load data is captured here, at the end of MEM
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            memWbAluResult <= '0;
            memWbRdData    <= '0;
            memWbDest      <= '0;
            memWbRegWrite  <= 1'b0;
            memWbMemToReg  <= 1'b0;
        end else begin
            memWbAluResult <= exMemAluResult;
            memWbRdData    <= memRdData;
            memWbDest      <= exMemDest;
            memWbRegWrite  <= exMemRegWrite;
            memWbMemToReg  <= exMemMemToReg;
        end
    end

    // WB
    assign wbData = memWbMemToReg ? memWbRdData : memWbAluResult;

endmodule

//--- tests/pipelineCore_checker.sv
`timescale 1ns/1ns

module pipelineCore_checker (
    input logic                          iClk,
    input logic                          iRst_n,
    input logic [mipsPkg::dataWidth-1:0] instAddr,
    input logic                          memWrite,
    input logic                          memRead
);
    import mipsPkg::*;

    // A single memory access per cycle
    assert property (@(posedge iClk) disable iff (!iRst_n)
        !(memWrite && memRead))
    else $error("memWrite and memRead high together");

    // PC holds on a stall, otherwise steps by one word
    assert property (@(posedge iClk) disable iff (!iRst_n)
        (instAddr == $past(instAddr)) || (instAddr == $past(instAddr) + pcStep))
    else $error("instAddr neither held nor advanced");

    assert property (@(posedge iClk) disable iff (!iRst_n)
        !$isunknown(memWrite))
    else $error("memWrite is unknown");

endmodule

//--- tests/pipelineCore_tb.sv
`timescale 1ns/1ns

module pipelineCore_tb;
    import mipsPkg::*;

    localparam int instDepth = 64;
    localparam int dataDepth = 128;
    localparam logic [dataWidth-1:0] dataBase = 32'h10010000;
    localparam int storeTimeout = 200;
    localparam int tailCycles = 20;

    logic                 iClk;
    logic                 iRst_n;
    logic [dataWidth-1:0] instAddr;
    logic [dataWidth-1:0] inst;
    logic [dataWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWrData;
    logic                 memWrite;
    logic                 memRead;
    logic [dataWidth-1:0] memRdData;

    logic [dataWidth-1:0] instMem [instDepth];
    logic [dataWidth-1:0] dataMem [dataDepth];

    // Expected stores from the vector file, observed stores from the bus
    logic [dataWidth-1:0] expAddr [$];
    logic [dataWidth-1:0] expData [$];
    logic [dataWidth-1:0] obsAddr [$];
    logic [dataWidth-1:0] obsData [$];

    pipelineCore pipelineCore_inst (
        .iClk      (iClk),
        .iRst_n    (iRst_n),
        .instAddr  (instAddr),
        .inst      (inst),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memWrite  (memWrite),
        .memRead   (memRead),
        .memRdData (memRdData)
    );

    bind pipelineCore pipelineCore_checker checker_inst (.*);

    initial begin
        iClk = 1'b0;
        forever begin
            #20 iClk = ~iClk;
        end
    end

    function automatic logic [dataWidth-1:0] fetchWord(input logic [dataWidth-1:0] addr);
        logic [dataWidth-1:0] offset;
        offset = addr - resetPc;
        if (offset[1:0] == 2'b00 && offset < instDepth * 4) begin
            return instMem[offset >> 2];
        end
        // Outside the program reads as sll r0,r0,0
        return '0;
    endfunction

    function automatic logic [dataWidth-1:0] readWord(input logic [dataWidth-1:0] addr);
        logic [dataWidth-1:0] offset;
        offset = addr - dataBase;
        if (offset[1:0] == 2'b00 && offset < dataDepth * 4) begin
            return dataMem[offset >> 2];
        end
        return addr ^ 32'h5a5a5a5a;
    endfunction

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkAddr(input string name, input logic [dataWidth-1:0] actual,
                             input logic [dataWidth-1:0] expected);
        string line;
        if (actual !== expected) begin
            line = $sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                             $time, name, actual, expected);
            stopOnError(line);
        end
    endtask

    task automatic checkData(input string name, input logic [dataWidth-1:0] actual,
                             input logic [dataWidth-1:0] expected);
        string line;
        if (actual !== expected) begin
            line = $sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                             $time, name, actual, expected);
            stopOnError(line);
        end
    endtask

    task automatic checkFetch(input logic [dataWidth-1:0] expected);
        string line;
        if (instAddr !== expected) begin
            line = $sformatf("MISMATCH at %0t ns: instAddr got %h expected %h",
                             $time, instAddr, expected);
            stopOnError(line);
        end
    endtask

    task automatic loadVectors();
        int fd;
        int code;
        string tag;
        string rest;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] word;
        fd = $fopen("tests/program_vectors.txt", "r");
        if (fd == 0) begin
            stopOnError("could not open tests/program_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code == 1) begin
                    if (tag == "#") begin
                        code = $fgets(rest, fd);
                    end else begin
                        code = $fscanf(fd, "%h %h", addr, word);
                        if (code != 2) begin
                            stopOnError("malformed line in the vector file");
                        end else if (tag == "I") begin
                            instMem[(addr - resetPc) >> 2] = word;
                        end else if (tag == "D") begin
                            dataMem[(addr - dataBase) >> 2] = word;
                        end else if (tag == "S") begin
                            expAddr.push_back(addr);
                            expData.push_back(word);
                        end else begin
                            stopOnError("unknown tag in the vector file");
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Inputs follow the DUT outputs 2 ns after each rising edge
    always @(posedge iClk) begin
        #2;
        inst      = fetchWord(instAddr);
        // Read data only while a load is in MEM
        memRdData = memRead ? readWord(memAddr) : '0;
    end

    // Data memory write and store capture use pre-edge values
    always @(posedge iClk) begin
        if (iRst_n && memWrite) begin
            obsAddr.push_back(memAddr);
            obsData.push_back(memWrData);
            if (memAddr - dataBase < dataDepth * 4) begin
                dataMem[(memAddr - dataBase) >> 2] = memWrData;
            end
        end
    end

    initial begin
        logic [dataWidth-1:0] wantAddr;
        logic [dataWidth-1:0] wantData;
        int cycles;
        int storeIdx;
        iRst_n    = 1'b0;
        inst      = '0;
        memRdData = '0;
        for (int i = 0; i < instDepth; i++) begin
            instMem[i] = '0;
        end
        for (int i = 0; i < dataDepth; i++) begin
            dataMem[i] = (dataBase + 4 * i) ^ 32'h5a5a5a5a;
        end
        loadVectors();

        repeat (8) @(posedge iClk);
        #2 iRst_n = 1'b1;

        // First cycle out of reset, then one step
        @(negedge iClk);
        checkFetch(resetPc);
        checkData("memWrite", {31'b0, memWrite}, '0);
        checkData("memRead", {31'b0, memRead}, '0);
        @(negedge iClk);
        checkFetch(resetPc + pcStep);

        storeIdx = 0;
        while (expAddr.size() > 0) begin
            wantAddr = expAddr.pop_front();
            wantData = expData.pop_front();
            cycles = 0;
            while (obsAddr.size() == 0 && cycles < storeTimeout) begin
                @(negedge iClk);
                cycles++;
            end
            if (obsAddr.size() == 0) begin
                stopOnError($sformatf("timed out waiting for store number %0d", storeIdx));
            end else begin
                checkAddr("memAddr", obsAddr.pop_front(), wantAddr);
                checkData("memWrData", obsData.pop_front(), wantData);
            end
            storeIdx++;
        end

        // Trailing no-ops must not store anything
        cycles = 0;
        while (cycles < tailCycles) begin
            @(negedge iClk);
            cycles++;
        end
        if (obsAddr.size() != 0) begin
            stopOnError("a store happened beyond the expected list");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- tests/program_vectors.txt
# Columns: tag address word
# I = instruction, D = initial data word, S = expected store in program order
I 004000a8 3c081001
I 004000ac 20010005
I 004000b0 2002fffd
I 004000b4 00221820
I 004000b8 ad030000
I 004000bc 00222022
I 004000c0 ad040004
I 004000c4 00412823
I 004000c8 00453024
I 004000cc 00223825
I 004000d0 00224826
I 004000d4 00225027
I 004000d8 ad050008
I 004000dc ad06000c
I 004000e0 ad070010
I 004000e4 ad090014
I 004000e8 ad0a0018
I 004000ec 0041582a
I 004000f0 284c0001
I 004000f4 2c4d0001
I 004000f8 2c2effff
I 004000fc ad0b001c
I 00400100 ad0c0020
I 00400104 ad0d0024
I 00400108 ad0e0028
I 0040010c 00017900
I 00400110 00028043
I 00400114 00028f02
I 00400118 00619004
I 0040011c 00229806
I 00400120 0022a007
I 00400124 ad0f002c
I 00400128 ad100030
I 0040012c ad110034
I 00400130 ad120038
I 00400134 ad13003c
I 00400138 ad140040
I 0040013c 30550ff0
I 00400140 34361230
I 00400144 26d70100
I 00400148 02f6c021
I 0040014c ad150044
I 00400150 ad160048
I 00400154 ad18004c
I 00400158 20200007
I 0040015c 0001c820
I 00400160 ad190050
I 00400164 8d1a0100
I 00400168 235b0011
I 0040016c ad1b0054
I 00400170 8d1c0104
I 00400174 ad1c0058
D 10010100 12345678
D 10010104 cafef00d
S 10010000 00000002
S 10010004 00000008
S 10010008 fffffff8
S 1001000c fffffff8
S 10010010 fffffffd
S 10010014 fffffff8
S 10010018 00000002
S 1001001c 00000001
S 10010020 00000001
S 10010024 00000000
S 10010028 00000001
S 1001002c 00000050
S 10010030 fffffffe
S 10010034 0000000f
S 10010038 00000014
S 1001003c 07ffffff
S 10010040 ffffffff
S 10010044 00000ff0
S 10010048 00001235
S 1001004c 0000256a
S 10010050 00000005
S 10010054 12345689
S 10010058 cafef00d

//--- verilog.f
src/mipsPkg.sv
src/mainDecoder.sv
src/aluDecoder.sv
src/alu.sv
src/regFile.sv
src/hazardUnit.sv
src/pipelineCore.sv
tests/pipelineCore_checker.sv
tests/pipelineCore_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the pipelineCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module pipelineCore_tb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv 2>&1)
simStatus=$?
echo "$output"

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
    exit 0
fi
exit 1
